// ==== logic/tcdm_dmr_pkg.sv ====
package tcdm_dmr_pkg;

  // ======================================================================
  // sizes
  // ======================================================================
  localparam int unsigned addr_w = 8;            // word address bits.
  localparam int unsigned data_w = 32;           // data word width.
  localparam int unsigned ecc_w  = 7;            // stored ECC bits per word.
  localparam int unsigned id_w   = 4;            // transaction id width.
  localparam int unsigned user_w = 2;            // user sideband width.
  localparam int unsigned depth  = 1 << addr_w;  // words in each bank.
  localparam int unsigned be_w   = data_w / 8;   // one enable per byte.
  localparam int unsigned cnt_w  = 8;            // saturating fault counter.

  // how much of the request is mirrored into the shadow bank.
  typedef enum logic [1:0] {
    copy_full      = 2'd0,  // everything is copied and compared.
    copy_no_ecc    = 2'd1,  // ECC fields are zeroed and left out of the compare.
    copy_no_data   = 2'd2,  // write data is zeroed and r_data is not compared.
    copy_ctrl_only = 2'd3   // neither data nor ECC is copied.
  } copy_mode_e;

  localparam copy_mode_e dmr_copy_mode = copy_full;  // mode used by the top level.

  // ======================================================================
  // channel payloads
  // ======================================================================
  typedef struct packed {
    logic              req;       // request strobe.
    logic [addr_w-1:0] add;       // word address.
    logic              wen;       // high for a read, low for a write.
    logic [be_w-1:0]   be;        // byte enables for a write.
    logic [data_w-1:0] data;      // write data.
    logic [user_w-1:0] user;      // user bits, echoed on the response.
    logic [id_w-1:0]   id;        // id, echoed on the response.
    logic [ecc_w-1:0]  ecc;       // ECC bits stored beside the word.
    logic              ereq;      // ECC copy of req.
    logic              r_ready;   // initiator takes the response.
    logic              r_eready;  // ECC copy of r_ready.
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;       // request accepted.
    logic              egnt;      // ECC copy of gnt.
    logic              r_valid;   // response present.
    logic              r_evalid;  // ECC copy of r_valid.
    logic [data_w-1:0] r_data;    // read word, zero for a write.
    logic [ecc_w-1:0]  r_ecc;     // stored ECC bits, zero for a write.
    logic [user_w-1:0] r_user;    // echoed user bits.
    logic [id_w-1:0]   r_id;      // echoed id.
    logic              r_opc;     // operation, high for a read.
  } tcdm_rsp_t;

  typedef struct packed {
    logic [cnt_w-1:0]  count;     // faults seen, stops at the top value.
    logic [addr_w-1:0] add;       // address of the first faulting request.
    logic [id_w-1:0]   id;        // id of the first faulting request.
    logic              valid;     // add and id hold a capture.
  } fault_info_t;

endpackage

// ==== logic/tcdm_bank.sv ====
`timescale 1ns/1ps

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcdm_dmr_pkg::tcdm_req_t req,
  output tcdm_dmr_pkg::tcdm_rsp_t rsp
);

  logic [tcdm_dmr_pkg::data_w-1:0] mem_q [tcdm_dmr_pkg::depth];  // word storage.
  logic [tcdm_dmr_pkg::ecc_w-1:0]  ecc_q [tcdm_dmr_pkg::depth];  // ECC storage.

  logic                            gnt;       // accept this cycle.
  logic                            valid_q;   // a response is waiting to be taken.
  logic [tcdm_dmr_pkg::data_w-1:0] r_data_q;  // held response word.
  logic [tcdm_dmr_pkg::ecc_w-1:0]  r_ecc_q;   // held response ECC bits.
  logic [tcdm_dmr_pkg::user_w-1:0] r_user_q;  // held user echo.
  logic [tcdm_dmr_pkg::id_w-1:0]   r_id_q;    // held id echo.
  logic                            r_opc_q;   // held operation.

  // a request is granted only when no response is still waiting, which
  // also gives the back-pressure from r_ready.
  assign gnt = req.req & ~valid_q;

  // ======================================================================
  // response handshake
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (gnt) begin
      valid_q <= 1'b1;  // response shows up the cycle after acceptance.
    end else if (req.r_ready) begin
      valid_q <= 1'b0;  // consumed, the bank may grant again.
    end
  end

  // write port with byte enables. the ECC word is stored as it arrives.
  always_ff @(posedge clk_i) begin
    if (gnt && !req.wen) begin
      for (int b = 0; b < tcdm_dmr_pkg::be_w; b++) begin
        if (req.be[b]) begin
          mem_q[req.add][b*8 +: 8] <= req.data[b*8 +: 8];  // only enabled bytes change.
        end
      end
      ecc_q[req.add] <= req.ecc;
    end
  end

  // response payload, loaded on acceptance and held until the next one.
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= req.wen ? mem_q[req.add] : '0;  // writes answer with zero.
      r_ecc_q  <= req.wen ? ecc_q[req.add] : '0;
      r_user_q <= req.user;
      r_id_q   <= req.id;
      r_opc_q  <= req.wen;                        // zero marks a write.
    end
  end

  always_comb begin
    rsp          = '0;
    rsp.gnt      = gnt;
    rsp.egnt     = gnt;      // ECC strobes mirror the plain ones.
    rsp.r_valid  = valid_q;
    rsp.r_evalid = valid_q;
    rsp.r_data   = r_data_q;
    rsp.r_ecc    = r_ecc_q;
    rsp.r_user   = r_user_q;
    rsp.r_id     = r_id_q;
    rsp.r_opc    = r_opc_q;
  end

  // a stalled response must not change under the initiator.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp.r_valid && !req.r_ready) |=> $stable(rsp.r_data))
    else $error("r_data changed while the response was stalled.");

endmodule

// ==== logic/tcdm_copy_source.sv ====
`timescale 1ns/1ps

module tcdm_copy_source #(
  parameter tcdm_dmr_pkg::copy_mode_e copy_mode = tcdm_dmr_pkg::copy_full
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tcdm_dmr_pkg::tcdm_req_t main_req,
  input  tcdm_dmr_pkg::tcdm_rsp_t main_rsp,
  output tcdm_dmr_pkg::tcdm_req_t copy_req,
  input  tcdm_dmr_pkg::tcdm_rsp_t copy_rsp,
  input  logic                    self_test,
  output logic                    fault
);

  // which field groups take part in the copy and the compare.
  localparam logic cmp_data = (copy_mode == tcdm_dmr_pkg::copy_full) ||
                              (copy_mode == tcdm_dmr_pkg::copy_no_ecc);
  localparam logic cmp_ecc  = (copy_mode == tcdm_dmr_pkg::copy_full) ||
                              (copy_mode == tcdm_dmr_pkg::copy_no_data);

  logic [tcdm_dmr_pkg::data_w-1:0] copy_r_data;  // shadow word after self-test flip.
  logic                            ctrl_fault;   // handshake or echo mismatch.
  logic                            data_fault;   // read word mismatch.
  logic                            ecc_fault;    // ECC strobe or word mismatch.
  logic                            fault_q;      // registered OR of the three.

  // ======================================================================
  // request mirror
  // ======================================================================
  always_comb begin
    copy_req = main_req;  // control fields always follow the main channel.
    if (!cmp_data) begin
      copy_req.data = '0;
    end
    if (!cmp_ecc) begin
      copy_req.ecc      = '0;
      copy_req.ereq     = 1'b0;
      copy_req.r_eready = 1'b0;
    end
  end

  // ======================================================================
  // response compare
  // ======================================================================
  // self-test flips bit zero of the shadow word so the data compare must fire.
  assign copy_r_data = copy_rsp.r_data ^
                       {{(tcdm_dmr_pkg::data_w-1){1'b0}}, self_test};

  // payload is only meaningful while a response is valid, so the echo fields
  // are qualified with r_valid. a differing r_valid is caught on its own.
  assign ctrl_fault = (main_rsp.gnt != copy_rsp.gnt) |
                      (main_rsp.r_valid != copy_rsp.r_valid) |
                      (main_rsp.r_valid & ((main_rsp.r_user != copy_rsp.r_user) |
                                           (main_rsp.r_id   != copy_rsp.r_id) |
                                           (main_rsp.r_opc  != copy_rsp.r_opc)));

  assign data_fault = cmp_data & main_rsp.r_valid &
                      (main_rsp.r_data != copy_r_data);

  assign ecc_fault = cmp_ecc & ((main_rsp.egnt != copy_rsp.egnt) |
                                (main_rsp.r_evalid != copy_rsp.r_evalid) |
                                (main_rsp.r_valid & (main_rsp.r_ecc != copy_rsp.r_ecc)));

  // one register stage keeps the wide compare off the fault consumers.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_q <= 1'b0;
    end else begin
      fault_q <= ctrl_fault | data_fault | ecc_fault;
    end
  end

  assign fault = fault_q;

  // both banks must agree on known values, so an X here means a bank leaked one.
  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(fault))
    else $error("fault is unknown.");

endmodule

// ==== logic/tcdm_fault_log.sv ====
`timescale 1ns/1ps

module tcdm_fault_log (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fault,
  input  tcdm_dmr_pkg::tcdm_req_t   req_seen,
  output tcdm_dmr_pkg::fault_info_t info
);

  logic [tcdm_dmr_pkg::addr_w-1:0] hist_add_q [2];  // request address history.
  logic [tcdm_dmr_pkg::id_w-1:0]   hist_id_q  [2];  // request id history.
  tcdm_dmr_pkg::fault_info_t       info_q;          // counter and first capture.

  // ======================================================================
  // request history
  // ======================================================================
  // a request on the bus in cycle n answers in n+1 and shows as fault in
  // n+2, so the entry two stages back belongs to the faulting response.
  always_ff @(posedge clk_i) begin
    hist_add_q[0] <= req_seen.add;
    hist_id_q[0]  <= req_seen.id;
    hist_add_q[1] <= hist_add_q[0];
    hist_id_q[1]  <= hist_id_q[0];
  end

  // ======================================================================
  // counter and capture
  // ======================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      info_q <= '0;
    end else if (fault) begin
      if (info_q.count != '1) begin
        info_q.count <= info_q.count + 1'b1;  // saturates at the top value.
      end
      if (!info_q.valid) begin
        info_q.add   <= hist_add_q[1];  // only the first fault is kept.
        info_q.id    <= hist_id_q[1];
        info_q.valid <= 1'b1;
      end
    end
  end

  assign info = info_q;

endmodule

// ==== logic/tcdm_dmr_top.sv ====
`timescale 1ns/1ps

module tcdm_dmr_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tcdm_dmr_pkg::tcdm_req_t   req,
  output tcdm_dmr_pkg::tcdm_rsp_t   rsp,
  input  logic                      self_test,
  output logic                      fault,
  output tcdm_dmr_pkg::fault_info_t info
);

  tcdm_dmr_pkg::tcdm_rsp_t main_rsp;    // main bank answer, also the port response.
  tcdm_dmr_pkg::tcdm_req_t shadow_req;  // mirrored request into the shadow bank.
  tcdm_dmr_pkg::tcdm_rsp_t shadow_rsp;  // shadow bank answer, only compared.
  logic                    fault_raw;   // registered mismatch from the copy source.

  // ======================================================================
  // redundant banks
  // ======================================================================
  // the initiator talks to the main bank directly.
  tcdm_bank i_main_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (req),
    .rsp    (main_rsp)
  );

  // the shadow bank sees only what the copy source lets through.
  tcdm_bank i_shadow_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (shadow_req),
    .rsp    (shadow_rsp)
  );

  // ======================================================================
  // checking
  // ======================================================================
  // mirrors the main request and compares the two answers.
  tcdm_copy_source #(
    .copy_mode (tcdm_dmr_pkg::dmr_copy_mode)
  ) i_copy_source (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .main_req  (req),
    .main_rsp  (main_rsp),
    .copy_req  (shadow_req),
    .copy_rsp  (shadow_rsp),
    .self_test (self_test),
    .fault     (fault_raw)
  );

  // counts faults and keeps the request behind the first one.
  tcdm_fault_log i_fault_log (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .fault    (fault_raw),
    .req_seen (req),
    .info     (info)
  );

  assign rsp   = main_rsp;   // the initiator only ever sees the main bank.
  assign fault = fault_raw;  // strobe is exported as registered.

endmodule

// ==== include/tcdm_dmr_tb_vectors.svh ====
`ifndef TCDM_DMR_TB_VECTORS_SVH
`define TCDM_DMR_TB_VECTORS_SVH

// each row holds the op, word address, write data, byte enables, self_test flag,
// r_ready stall cycles and the expected fault-count increment.
localparam logic [1:0] op_wr     = 2'd0;  // write with the data column.
localparam logic [1:0] op_rd     = 2'd1;  // read, data column unused.
localparam logic [1:0] op_wr_rnd = 2'd2;  // write with xorshift data.

typedef struct packed {
  logic [1:0]  op;
  logic [7:0]  add;
  logic [31:0] data;
  logic [3:0]  be;
  logic        self_test;
  logic [2:0]  stall;
  logic [1:0]  inc;
} row_t;

localparam int n_rows = 15;

localparam row_t rows [n_rows] = '{
  '{op_wr,     8'h10, 32'h1122_3344, 4'hf, 1'b0, 3'd0, 2'd0},  // fill before any read.
  '{op_wr,     8'h20, 32'ha5a5_a5a5, 4'hf, 1'b0, 3'd0, 2'd0},
  '{op_wr,     8'h10, 32'hdead_beef, 4'h5, 1'b0, 3'd0, 2'd0},  // bytes 0 and 2 only.
  '{op_rd,     8'h10, 32'h0,         4'h0, 1'b0, 3'd0, 2'd0},
  '{op_rd,     8'h20, 32'h0,         4'h0, 1'b0, 3'd3, 2'd0},  // longest stall.
  '{op_wr_rnd, 8'h30, 32'h0,         4'hf, 1'b0, 3'd0, 2'd0},
  '{op_wr_rnd, 8'h31, 32'h0,         4'hf, 1'b0, 3'd0, 2'd0},
  '{op_rd,     8'h30, 32'h0,         4'h0, 1'b0, 3'd0, 2'd0},
  '{op_rd,     8'h31, 32'h0,         4'h0, 1'b0, 3'd2, 2'd0},
  '{op_rd,     8'h10, 32'h0,         4'h0, 1'b1, 3'd0, 2'd1},  // first fault is captured.
  '{op_rd,     8'h20, 32'h0,         4'h0, 1'b0, 3'd0, 2'd0},
  '{op_rd,     8'h30, 32'h0,         4'h0, 1'b1, 3'd0, 2'd1},  // capture must not move.
  '{op_wr_rnd, 8'h20, 32'h0,         4'ha, 1'b0, 3'd0, 2'd0},
  '{op_rd,     8'h20, 32'h0,         4'h0, 1'b0, 3'd1, 2'd0},
  '{op_rd,     8'h31, 32'h0,         4'h0, 1'b1, 3'd1, 2'd2}   // stalled so it fires twice.
};

`endif

// ==== sim/tb_tcdm_dmr.sv ====
`timescale 1ns/1ps

module tb_tcdm_dmr;

  `include "tcdm_dmr_tb_vectors.svh"

  logic                      clk_i;
  logic                      rst_ni;
  tcdm_dmr_pkg::tcdm_req_t   req;
  tcdm_dmr_pkg::tcdm_rsp_t   rsp;
  logic                      self_test;
  logic                      fault;
  tcdm_dmr_pkg::fault_info_t info;

  logic [tcdm_dmr_pkg::data_w-1:0] model_mem [tcdm_dmr_pkg::depth];  // expected words.
  logic [tcdm_dmr_pkg::ecc_w-1:0]  model_ecc [tcdm_dmr_pkg::depth];  // expected ECC bits.
  tcdm_dmr_pkg::fault_info_t       exp_info;                       // expected fault log.
  logic [31:0]                     rnd_state;                      // xorshift state.
  int                              cycles = 0;                     // clock edges so far.
  int                              limit;                          // edges allowed in total.

  tcdm_dmr_top i_tcdm_dmr_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req       (req),
    .rsp       (rsp),
    .self_test (self_test),
    .fault     (fault),
    .info      (info)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period.

  // ======================================================================
  // helpers
  // ======================================================================
  task automatic stop_on_error();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error.");
  endtask

  task automatic check_rsp(input tcdm_dmr_pkg::tcdm_rsp_t exp,
                           input tcdm_dmr_pkg::tcdm_rsp_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns rsp: expected %h, got %h", $time, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_info(input tcdm_dmr_pkg::fault_info_t exp,
                            input tcdm_dmr_pkg::fault_info_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns info: expected %h, got %h", $time, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  function automatic logic [31:0] xorshift_next(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int run_limit();
    int max_stall;
    max_stall = 0;
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].stall > max_stall) max_stall = rows[i].stall;
    end
    return n_rows * (max_stall + 6) + 20;  // a row needs stall plus three edges.
  endfunction

  // cycle budget for the whole run.
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d clock cycles.", limit);
      stop_on_error();
    end
  end

  // ======================================================================
  // one table row, entered and left on a falling edge
  // ======================================================================
  task automatic run_row(input int idx);
    row_t                    r;
    tcdm_dmr_pkg::tcdm_rsp_t exp;
    logic [31:0]             wdata;
    logic                    rd;
    int                      b;
    int                      s;
    r     = rows[idx];
    rd    = (r.op == op_rd);
    wdata = r.data;
    if (r.op == op_wr_rnd) begin
      rnd_state = xorshift_next(rnd_state);
      wdata     = rnd_state;
    end
    req         = '0;
    req.req     = 1'b1;
    req.ereq    = 1'b1;
    req.add     = r.add;
    req.wen     = rd;                                          // high means read.
    req.be      = r.be;
    req.data    = rd ? '0 : wdata;
    req.user    = idx[1:0];
    req.id      = idx[3:0];
    req.ecc     = rd ? '0 : (wdata[6:0] ^ r.add[6:0]);          // any stored pattern works.
    self_test   = r.self_test;
    exp          = '0;                                         // gnt low while response waits.
    exp.r_valid  = 1'b1;
    exp.r_evalid = 1'b1;
    exp.r_data   = rd ? model_mem[r.add] : '0;                  // a write answers with zero.
    exp.r_ecc    = rd ? model_ecc[r.add] : '0;
    exp.r_user   = idx[1:0];
    exp.r_id     = idx[3:0];
    exp.r_opc    = rd;
    if (!rd) begin
      for (b = 0; b < tcdm_dmr_pkg::be_w; b++) begin
        if (r.be[b]) model_mem[r.add][b*8 +: 8] = wdata[b*8 +: 8];
      end
      model_ecc[r.add] = req.ecc;
    end
    #1;                                                        // gnt is combinational.
    while (!rsp.gnt) begin
      @(negedge clk_i);
      #1;
    end
    check_bit("egnt", 1'b1, rsp.egnt);                         // ECC grant follows gnt.
    @(negedge clk_i);                                          // accepted on the edge just past.
    check_rsp(exp, rsp);
    check_bit("fault", 1'b0, fault);
    for (s = 0; s < r.stall; s++) begin                        // request stays up as a probe.
      @(negedge clk_i);
      check_rsp(exp, rsp);
      check_bit("fault", r.self_test, fault);
    end
    req          = '0;                                         // address and id leave the bus.
    req.r_ready  = 1'b1;
    req.r_eready = 1'b1;
    @(negedge clk_i);
    check_bit("r_valid", 1'b0, rsp.r_valid);
    check_bit("gnt", 1'b0, rsp.gnt);
    check_bit("fault", r.self_test, fault);
    req       = '0;
    self_test = 1'b0;
    for (s = 0; s < r.inc; s++) begin
      if (exp_info.count != 8'hff) exp_info.count = exp_info.count + 1'b1;
    end
    if (r.inc != 0 && !exp_info.valid) begin                   // only the first fault is kept.
      exp_info.add   = r.add;
      exp_info.id    = idx[3:0];
      exp_info.valid = 1'b1;
    end
    @(negedge clk_i);                                          // count lags fault by one edge.
    check_info(exp_info, info);
    check_bit("fault", 1'b0, fault);
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================
  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    req       = '0;
    self_test = 1'b0;
    rnd_state = 32'd95560;
    exp_info  = '0;
    limit     = run_limit();
    repeat (2) @(negedge clk_i);                               // two rising edges in reset.
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("gnt", 1'b0, rsp.gnt);
    check_bit("r_valid", 1'b0, rsp.r_valid);
    check_bit("fault", 1'b0, fault);
    check_info(exp_info, info);
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
logic/tcdm_dmr_pkg.sv
logic/tcdm_bank.sv
logic/tcdm_copy_source.sv
logic/tcdm_fault_log.sv
logic/tcdm_dmr_top.sv
sim/tb_tcdm_dmr.sv
